//--- list.f
+incdir+src
src/uart_line_pkg.sv
src/uart_host_pkg.sv
src/stream_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_stream.sv
verif/tb_uart_stream.sv

//--- verif/tb_uart_stream.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_macros.svh"

module tb_uart_stream;

    // Prescale of 2 with 8x oversampling gives 16 clk cycles per bit.
    localparam int BIT_CYCLES  = 16;
    localparam int PACKETS     = 40;
    localparam int OVR_PACKETS = 24;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic [`UART_PRESCALE_W-1:0] prescale;
    uart_host_pkg::uart_status_t status;
    logic [`UART_DW-1:0]         utx_tdata;
    logic                        utx_tvalid;
    logic                        utx_tlast;
    logic                        utx_tready;
    logic [`UART_DW-1:0]         urx_tdata;
    logic                        urx_tvalid;
    logic                        urx_tlast;
    logic                        urx_tready;
    logic                        txd;
    logic                        rxd;

    // High selects txd looped back to rxd, low selects the bit driver.
    logic                        loop_en;
    logic                        bit_line;

    integer                      seed;
    string                       cur_test;
    int                          ready_mode;
    int                          rx_count;
    int                          frame_pulses;
    int                          overrun_pulses;
    logic                        tx_seen;

    // Entries are {last, data}.
    logic [`UART_DW:0]           byte_q[$];
    logic [`UART_DW:0]           model_q[$];

    assign rxd = loop_en ? txd : bit_line;

    always #20 clk = ~clk;

    uart_stream i_uart_stream (
        .clk        (clk),
        .rst_n      (rst_n),
        .prescale   (prescale),
        .status     (status),
        .utx_tdata  (utx_tdata),
        .utx_tvalid (utx_tvalid),
        .utx_tlast  (utx_tlast),
        .utx_tready (utx_tready),
        .urx_tdata  (urx_tdata),
        .urx_tvalid (urx_tvalid),
        .urx_tlast  (urx_tlast),
        .urx_tready (urx_tready),
        .txd        (txd),
        .rxd        (rxd)
    );

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s: %s expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
        abort_run();
    endtask

    task automatic report_fault(input string what);
        $display("%s: %s", cur_test, what);
        abort_run();
    endtask

    // Samples handshakes and pulses before the edge, then drives inputs 2 ns after it.
    task automatic advance_cycle();
        logic              tx_fire;
        logic              rx_fire;
        logic [`UART_DW:0] got;
        logic [`UART_DW:0] exp;
        logic [31:0]       r;
        #1;
        tx_fire = utx_tvalid && utx_tready;
        rx_fire = urx_tvalid && urx_tready;
        got     = {urx_tlast, urx_tdata};
        if (status.frame_error === 1'b1) begin
            frame_pulses++;
        end
        if (status.overrun_error === 1'b1) begin
            overrun_pulses++;
        end
        if (status.tx_active === 1'b1) begin
            tx_seen = 1'b1;
        end
        @(posedge clk);
        #2;
        if (tx_fire) begin
            byte_q.delete(0);
        end
        if (rx_fire) begin
            assert (model_q.size() != 0)
            else report_fault("A byte was received that was never sent.");
            exp = model_q.pop_front();
            assert (got === exp)
            else report_mismatch("received {last, data}", exp, got);
            rx_count++;
        end
        utx_tvalid = (byte_q.size() != 0);
        if (byte_q.size() != 0) begin
            {utx_tlast, utx_tdata} = byte_q[0];
        end
        case (ready_mode)
            0: urx_tready = 1'b0;
            1: urx_tready = 1'b1;
            default: begin
                r          = $random(seed);
                urx_tready = r[0];
            end
        endcase
    endtask

    task automatic queue_packet(input int len);
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            byte_q.push_back({(i == len - 1), r[`UART_DW-1:0]});
            model_q.push_back({(i == len - 1), r[`UART_DW-1:0]});
        end
    endtask

    task automatic wait_written(input int limit);
        int n;
        n = 0;
        while (byte_q.size() != 0) begin
            assert (n < limit)
            else report_fault("Timeout while writing to the transmit FIFO.");
            advance_cycle();
            n++;
        end
    endtask

    // Waits for the transmit side, and the receive side when with_rx is set, to go quiet.
    task automatic wait_quiet(input int limit, input logic with_rx);
        int n;
        n = 0;
        while (byte_q.size() != 0 || status.tx_active !== 1'b0 ||
               (with_rx && status.rx_active !== 1'b0)) begin
            assert (n < limit)
            else report_fault("Timeout while waiting for the activity bits to clear.");
            advance_cycle();
            n++;
        end
    endtask

    task automatic send_frame(input logic [`UART_DW-1:0] data, input logic stop_bit);
        logic [`UART_DW+1:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int b = 0; b < `UART_DW + 2; b++) begin
            bit_line = frame[b];
            repeat (BIT_CYCLES) advance_cycle();
        end
        bit_line = 1'b1;
        repeat (BIT_CYCLES) advance_cycle();
    endtask

    initial begin
        logic [31:0] r;
        int          total;
        rst_n          = 1'b0;
        prescale       = 16'd2;
        utx_tdata      = '0;
        utx_tvalid     = 1'b0;
        utx_tlast      = 1'b0;
        urx_tready     = 1'b0;
        loop_en        = 1'b0;
        bit_line       = 1'b1;
        seed           = 9;
        ready_mode     = 0;
        rx_count       = 0;
        frame_pulses   = 0;
        overrun_pulses = 0;
        tx_seen        = 1'b0;
        cur_test       = "reset";

        for (int c = 0; c < 10; c++) begin
            advance_cycle();
            assert (utx_tready === 1'b0 && urx_tvalid === 1'b0)
            else report_fault("A stream handshake was active during reset.");
        end
        rst_n = 1'b1;
        advance_cycle();
        advance_cycle();
        assert (txd === 1'b1) else report_mismatch("txd", 1, txd);
        assert (status === 4'b0000) else report_mismatch("status", 0, status);
        assert (urx_tvalid === 1'b0) else report_mismatch("urx_tvalid", 0, urx_tvalid);
        assert (utx_tready === 1'b1) else report_mismatch("utx_tready", 1, utx_tready);

        cur_test   = "loopback";
        loop_en    = 1'b1;
        ready_mode = 2;
        total      = 0;
        for (int p = 0; p < PACKETS; p++) begin
            r = $random(seed);
            queue_packet(1 + int'(r % 6));
            total += 1 + int'(r % 6);
            wait_written(5000);
        end
        wait_quiet(20000, 1'b1);
        assert (rx_count == total) else report_mismatch("byte count", total, rx_count);
        assert (model_q.size() == 0) else report_fault("Bytes were lost in loopback.");
        assert (frame_pulses == 0 && overrun_pulses == 0)
        else report_fault("An error pulse appeared during clean loopback.");
        assert (tx_seen) else report_fault("tx_active was never seen high.");
        assert (status === 4'b0000) else report_mismatch("status", 0, status);

        cur_test   = "frame error";
        loop_en    = 1'b0;
        ready_mode = 1;
        rx_count   = 0;
        r = $random(seed);
        send_frame(r[`UART_DW-1:0], 1'b0);
        r = $random(seed);
        model_q.push_back({1'b1, r[`UART_DW-1:0]});
        send_frame(r[`UART_DW-1:0], 1'b1);
        wait_quiet(2000, 1'b1);
        assert (frame_pulses == 1) else report_mismatch("frame_error pulses", 1, frame_pulses);
        assert (rx_count == 1) else report_mismatch("byte count", 1, rx_count);

        cur_test   = "overrun";
        loop_en    = 1'b1;
        ready_mode = 0;
        rx_count   = 0;
        for (int p = 0; p < OVR_PACKETS; p++) begin
            queue_packet(1);
        end
        wait_written(20000);
        wait_quiet(20000, 1'b0);
        ready_mode = 1;
        wait_quiet(5000, 1'b1);
        assert (rx_count + overrun_pulses == OVR_PACKETS)
        else report_mismatch("received plus overruns", OVR_PACKETS, rx_count + overrun_pulses);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/uart_stream.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_macros.svh"

module uart_stream (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`UART_PRESCALE_W-1:0] prescale,
    output uart_host_pkg::uart_status_t      status,

    input  wire logic [`UART_DW-1:0]         utx_tdata,
    input  wire logic                        utx_tvalid,
    input  wire logic                        utx_tlast,
    output logic                             utx_tready,

    output logic [`UART_DW-1:0]              urx_tdata,
    output logic                             urx_tvalid,
    output logic                             urx_tlast,
    input  wire logic                        urx_tready,

    output logic                             txd,
    input  wire logic                        rxd
);

    logic [`UART_DW-1:0] tx_tdata;
    logic                tx_tvalid;
    logic                tx_tlast;
    logic                tx_tready;
    logic                tx_fifo_empty;
    logic                tx_busy;

    logic [`UART_DW-1:0] rx_tdata;
    logic                rx_tvalid;
    logic                rx_tlast;
    logic                rx_tready;
    logic                rx_fifo_empty;
    logic                rx_busy;
    logic                frame_error;
    logic                overrun_error;

    stream_fifo #(
        .DW (`UART_DW),
        .AW (`UART_AW)
    ) tx_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .d_in        (utx_tdata),
        .d_in_valid  (utx_tvalid),
        .d_in_last   (utx_tlast),
        .d_in_ready  (utx_tready),
        .d_out       (tx_tdata),
        .d_out_valid (tx_tvalid),
        .d_out_last  (tx_tlast),
        .d_out_ready (tx_tready),
        .fifo_empty  (tx_fifo_empty)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .prescale (prescale),
        .s_tdata  (tx_tdata),
        .s_tvalid (tx_tvalid),
        .s_tlast  (tx_tlast),
        .s_tready (tx_tready),
        .txd      (txd),
        .busy     (tx_busy)
    );

    uart_rx i_uart_rx (
        .clk           (clk),
        .rst_n         (rst_n),
        .prescale      (prescale),
        .rxd           (rxd),
        .m_tdata       (rx_tdata),
        .m_tvalid      (rx_tvalid),
        .m_tlast       (rx_tlast),
        .m_tready      (rx_tready),
        .busy          (rx_busy),
        .frame_error   (frame_error),
        .overrun_error (overrun_error)
    );

    // The last flag comes from the receiver's idle-gap rule.
    stream_fifo #(
        .DW (`UART_DW),
        .AW (`UART_AW)
    ) rx_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .d_in        (rx_tdata),
        .d_in_valid  (rx_tvalid),
        .d_in_last   (rx_tlast),
        .d_in_ready  (rx_tready),
        .d_out       (urx_tdata),
        .d_out_valid (urx_tvalid),
        .d_out_last  (urx_tlast),
        .d_out_ready (urx_tready),
        .fifo_empty  (rx_fifo_empty)
    );

    assign status.frame_error   = frame_error;
    assign status.overrun_error = overrun_error;
    assign status.rx_active     = rx_busy || !rx_fifo_empty;
    assign status.tx_active     = tx_busy || !tx_fifo_empty;

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_macros.svh"

module uart_rx (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`UART_PRESCALE_W-1:0] prescale,

    input  wire logic                        rxd,

    output logic [`UART_DW-1:0]              m_tdata,
    output logic                             m_tvalid,
    output logic                             m_tlast,
    input  wire logic                        m_tready,

    output logic                             busy,
    output logic                             frame_error,
    output logic                             overrun_error
);

    localparam int TW       = `UART_PRESCALE_W + $clog2(`UART_OVERSAMPLE);
    localparam int GAP_BITS = 10;
    localparam int CW       = $clog2(GAP_BITS);

    uart_line_pkg::line_phase_t phase;

    logic [TW-1:0]       bit_time;
    logic [TW-1:0]       half_time;
    logic [TW-1:0]       timer;
    logic [CW-1:0]       bit_idx;
    logic [`UART_DW-1:0] shreg;

    logic                rxd_meta;
    logic                rxd_sync;
    logic                rxd_prev;
    logic                fall;

    // One-entry hold register; decided means its last flag is known.
    logic [`UART_DW-1:0] hold_data;
    logic                hold_full;
    logic                hold_decided;
    logic                hold_last;
    logic                undecided;
    logic                push;

    assign bit_time  = TW'(prescale) * TW'(`UART_OVERSAMPLE);
    assign half_time = bit_time >> 1;

    assign fall      = rxd_prev && !rxd_sync;
    assign undecided = hold_full && !hold_decided;

    assign m_tdata  = hold_data;
    assign m_tlast  = hold_last;
    assign m_tvalid = hold_full && hold_decided;
    assign push     = m_tvalid && m_tready;

    assign busy = (phase != uart_line_pkg::line_idle) || hold_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase         <= uart_line_pkg::line_idle;
            timer         <= '0;
            bit_idx       <= '0;
            hold_full     <= 1'b0;
            hold_decided  <= 1'b0;
            frame_error   <= 1'b0;
            overrun_error <= 1'b0;
        end else begin
            frame_error   <= 1'b0;
            overrun_error <= 1'b0;
            if (push) begin
                hold_full <= 1'b0;
            end

            case (phase)
                uart_line_pkg::line_idle: begin
                    if (fall) begin
                        phase <= uart_line_pkg::line_start;
                        timer <= half_time - 1'b1;
                    end
                end
                uart_line_pkg::line_start: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else if (!rxd_sync) begin
                        // A real start bit, so the held byte was not the packet end.
                        phase   <= uart_line_pkg::line_data;
                        timer   <= bit_time - 1'b1;
                        bit_idx <= '0;
                        if (undecided) begin
                            hold_decided <= 1'b1;
                            hold_last    <= 1'b0;
                        end
                    end else begin
                        // Glitch. Restart the idle count if a byte still waits on it.
                        phase   <= undecided ? uart_line_pkg::line_gap
                                             : uart_line_pkg::line_idle;
                        timer   <= bit_time - 1'b1;
                        bit_idx <= '0;
                    end
                end
                uart_line_pkg::line_data: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        timer <= bit_time - 1'b1;
                        shreg <= {rxd_sync, shreg[`UART_DW-1:1]};
                        if (bit_idx == CW'(`UART_DW - 1)) begin
                            phase <= uart_line_pkg::line_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_line_pkg::line_stop: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else if (!rxd_sync) begin
                        frame_error <= 1'b1;
                        phase       <= uart_line_pkg::line_idle;
                    end else if (hold_full && !push) begin
                        overrun_error <= 1'b1;
                        phase         <= uart_line_pkg::line_idle;
                    end else begin
                        hold_data    <= shreg;
                        hold_full    <= 1'b1;
                        hold_decided <= 1'b0;
                        phase        <= uart_line_pkg::line_gap;
                        timer        <= bit_time - 1'b1;
                        bit_idx      <= '0;
                    end
                end
                uart_line_pkg::line_gap: begin
                    if (fall) begin
                        phase <= uart_line_pkg::line_start;
                        timer <= half_time - 1'b1;
                    end else if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else if (bit_idx == CW'(GAP_BITS - 1)) begin
                        // A full character of idle line ends the packet.
                        hold_decided <= 1'b1;
                        hold_last    <= 1'b1;
                        phase        <= uart_line_pkg::line_idle;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        timer   <= bit_time - 1'b1;
                    end
                end
                default: begin
                    phase <= uart_line_pkg::line_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_macros.svh"

module uart_tx (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`UART_PRESCALE_W-1:0] prescale,

    input  wire logic [`UART_DW-1:0]         s_tdata,
    input  wire logic                        s_tvalid,
    input  wire logic                        s_tlast,
    output logic                             s_tready,

    output logic                             txd,
    output logic                             busy
);

    localparam int TW       = `UART_PRESCALE_W + $clog2(`UART_OVERSAMPLE);
    localparam int GAP_BITS = 10;
    localparam int CW       = $clog2(GAP_BITS);

    uart_line_pkg::line_phase_t phase;

    logic [TW-1:0]       bit_time;
    logic [TW-1:0]       timer;
    logic [CW-1:0]       bit_idx;
    logic [`UART_DW-1:0] shreg;
    logic                last_q;

    assign bit_time = TW'(prescale) * TW'(`UART_OVERSAMPLE);

    assign s_tready = (phase == uart_line_pkg::line_idle);
    assign busy     = (phase != uart_line_pkg::line_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase   <= uart_line_pkg::line_idle;
            timer   <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else if (phase == uart_line_pkg::line_idle) begin
            if (s_tvalid) begin
                phase  <= uart_line_pkg::line_start;
                timer  <= bit_time - 1'b1;
                shreg  <= s_tdata;
                last_q <= s_tlast;
                txd    <= 1'b0;
            end
        end else if (timer != '0) begin
            timer <= timer - 1'b1;
        end else begin
            // A bit time has run out.
            timer <= bit_time - 1'b1;
            case (phase)
                uart_line_pkg::line_start: begin
                    phase   <= uart_line_pkg::line_data;
                    bit_idx <= '0;
                    txd     <= shreg[0];
                    shreg   <= shreg >> 1;
                end
                uart_line_pkg::line_data: begin
                    if (bit_idx == CW'(`UART_DW - 1)) begin
                        phase <= uart_line_pkg::line_stop;
                        txd   <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        txd     <= shreg[0];
                        shreg   <= shreg >> 1;
                    end
                end
                uart_line_pkg::line_stop: begin
                    // After the last byte of a packet the line rests for a full character.
                    if (last_q) begin
                        phase   <= uart_line_pkg::line_gap;
                        bit_idx <= '0;
                    end else begin
                        phase <= uart_line_pkg::line_idle;
                    end
                end
                uart_line_pkg::line_gap: begin
                    if (bit_idx == CW'(GAP_BITS - 1)) begin
                        phase <= uart_line_pkg::line_idle;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    phase <= uart_line_pkg::line_idle;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/stream_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
    parameter int DW = 8,
    parameter int AW = 4
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire logic [DW-1:0] d_in,
    input  wire logic          d_in_valid,
    input  wire logic          d_in_last,
    output logic               d_in_ready,

    output logic [DW-1:0]      d_out,
    output logic               d_out_valid,
    output logic               d_out_last,
    input  wire logic          d_out_ready,

    output logic               fifo_empty
);

    localparam int DEPTH = 1 << AW;

    logic [DW-1:0] mem_data [DEPTH];
    logic          mem_last [DEPTH];

    // Pointers carry one extra bit so that full and empty can be told apart.
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          fifo_full;
    logic          in_en;
    logic          push;
    logic          pop;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // A full FIFO still takes a word when the output side pops in the same cycle.
    assign d_in_ready = in_en && (!fifo_full || d_out_ready);
    assign push       = d_in_valid && d_in_ready;

    assign d_out_valid = !fifo_empty;
    assign d_out       = mem_data[rd_ptr[AW-1:0]];
    assign d_out_last  = mem_last[rd_ptr[AW-1:0]];
    assign pop         = d_out_valid && d_out_ready;

    // Keeps the input side closed while reset is held.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_en <= 1'b0;
        end else begin
            in_en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr[AW-1:0]] <= d_in;
            mem_last[wr_ptr[AW-1:0]] <= d_in_last;
        end
    end

endmodule

`default_nettype wire

//--- src/uart_host_pkg.sv
`default_nettype none

package uart_host_pkg;

    // Status word seen by the host.
    // The error bits are one-cycle pulses, the activity bits are levels.
    typedef struct packed {
        logic frame_error;
        logic overrun_error;
        logic rx_active;
        logic tx_active;
    } uart_status_t;

endpackage

`default_nettype wire

//--- src/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

    // Phase of a frame on the serial line.
    // The gap phase covers the idle time that follows the last byte of a packet.
    typedef enum logic [2:0] {
        line_idle,
        line_start,
        line_data,
        line_stop,
        line_gap
    } line_phase_t;

endpackage

`default_nettype wire

//--- src/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Data bits carried by one character on the line.
`define UART_DW 8

// Address width of each FIFO, which then holds 16 entries.
`define UART_AW 4

// Bit-timer ticks per bit; one bit lasts prescale times this many clk cycles.
`define UART_OVERSAMPLE 8

// Width of the prescale input.
`define UART_PRESCALE_W 16

`endif
